//--- source/x86_pkg.sv
package x86_pkg;

    // ======================================================================
    // Basic data types
    // ======================================================================

    typedef logic [15:0] word_t;
    typedef logic [7:0] byte_t;
    typedef logic [2:0] reg_num_t;

    // ======================================================================
    // General register numbers in x86 encoding order
    // ======================================================================

    localparam reg_num_t REG_AX = 3'd0;
    localparam reg_num_t REG_CX = 3'd1;
    localparam reg_num_t REG_DX = 3'd2;
    localparam reg_num_t REG_BX = 3'd3;
    localparam reg_num_t REG_SP = 3'd4;
    localparam reg_num_t REG_BP = 3'd5;
    localparam reg_num_t REG_SI = 3'd6;
    localparam reg_num_t REG_DI = 3'd7;

    // ======================================================================
    // Prefetch FIFO sizing
    // ======================================================================

    // Depth must stay a power of two so the pointers wrap on their own
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_WIDTH = 3;

endpackage

//--- source/prefetch_fifo.sv
module prefetch_fifo import x86_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  wr_en,
    input  byte_t wr_data,
    output logic  full,
    input  logic  rd_en,
    output byte_t rd_data,
    output logic  empty
);

    byte_t mem [FIFO_DEPTH];
    logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
    logic [FIFO_PTR_WIDTH:0] count;
    logic do_write;
    logic do_read;

    assign full = count == (FIFO_PTR_WIDTH + 1)'(FIFO_DEPTH);
    assign empty = count == '0;

    assign do_write = wr_en & ~full;
    assign do_read = rd_en & ~empty;

    always_ff @(posedge clk) begin
        if (do_write)
            mem[wr_ptr] <= wr_data;
    end

    // Popped byte appears on rd_data the cycle after rd_en
    always_ff @(posedge clk) begin
        if (do_read)
            rd_data <= mem[rd_ptr];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_read)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_write, do_read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- source/register_file.sv
module register_file import x86_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     wr_en,
    input  reg_num_t wr_sel,
    input  word_t    wr_data,
    input  reg_num_t sel_base,
    input  reg_num_t sel_index,
    output word_t    base_value,
    output word_t    index_value
);

    word_t regs [8];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wr_sel] <= wr_data;
        end
    end

    // Asynchronous reads let the decoder form the address without waiting
    assign base_value = regs[sel_base];
    assign index_value = regs[sel_index];

endmodule

//--- source/immediate_reader.sv
module immediate_reader import x86_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  start,
    input  logic  is_8bit,
    output logic  fifo_rd_en,
    input  byte_t fifo_rd_data,
    input  logic  fifo_empty,
    output logic  complete,
    output word_t immediate
);

    typedef enum logic [1:0] {
        IDLE,
        FETCH_LO,
        FETCH_HI,
        DONE
    } state_t;

    state_t state;
    state_t next_state;

    // FETCH_LO and FETCH_HI are the cycles where that byte sits on fifo_rd_data
    always_comb begin
        next_state = state;
        fifo_rd_en = 1'b0;
        case (state)
            IDLE: begin
                if (start && !fifo_empty) begin
                    fifo_rd_en = 1'b1;
                    next_state = FETCH_LO;
                end
            end
            FETCH_LO: begin
                if (is_8bit) begin
                    next_state = DONE;
                end else if (!fifo_empty) begin
                    fifo_rd_en = 1'b1;
                    next_state = FETCH_HI;
                end
            end
            FETCH_HI: next_state = DONE;
            DONE: begin
                if (!start)
                    next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            state <= IDLE;
        else
            state <= next_state;
    end

    // While stalled in FETCH_LO the same byte is captured again, which is harmless
    always_ff @(posedge clk) begin
        if (state == FETCH_LO)
            immediate <= is_8bit ? {{8{fifo_rd_data[7]}}, fifo_rd_data}
                                 : {8'h00, fifo_rd_data};
        else if (state == FETCH_HI)
            immediate[15:8] <= fifo_rd_data;
    end

    assign complete = state == DONE;

endmodule

//--- source/modrm_decode.sv
module modrm_decode import x86_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    output logic     busy,
    output logic     complete,
    input  logic     clear,
    output word_t    effective_address,
    output reg_num_t regnum,
    output logic     rm_is_reg,
    output reg_num_t rm_regnum,
    output logic     bp_as_base,
    output reg_num_t reg_sel_base,
    output reg_num_t reg_sel_index,
    input  word_t    base_value,
    input  word_t    index_value,
    output logic     fifo_rd_en,
    input  byte_t    fifo_rd_data,
    input  logic     fifo_empty,
    output logic     immed_start,
    input  logic     immed_complete,
    output logic     immed_is_8bit,
    input  word_t    immediate
);

    byte_t modrm;
    logic modrm_byte_read;
    logic latch_modrm_byte;
    logic started;
    logic registers_fetched;
    word_t cached_address;
    word_t calc_address;
    word_t displacement;
    logic [1:0] mode;
    reg_num_t reg_field;
    reg_num_t rm_field;
    logic has_address;
    logic has_immediate;
    logic direct_address;

    // ======================================================================
    // Field extraction
    // ======================================================================

    // Fresh byte comes straight off the FIFO, later cycles use the held copy
    assign mode = latch_modrm_byte ? fifo_rd_data[7:6] : modrm[7:6];
    assign reg_field = latch_modrm_byte ? fifo_rd_data[5:3] : modrm[5:3];
    assign rm_field = latch_modrm_byte ? fifo_rd_data[2:0] : modrm[2:0];

    assign has_address = mode != 2'b11;
    assign direct_address = mode == 2'b00 && rm_field == 3'b110;
    assign has_immediate = direct_address || mode == 2'b01 || mode == 2'b10;

    // ======================================================================
    // Handshake
    // ======================================================================

    assign fifo_rd_en = ~fifo_empty & start & ~modrm_byte_read & ~complete;
    assign complete = modrm_byte_read && (!has_address || registers_fetched) &&
                      (!has_immediate || immed_complete);
    assign busy = (start | started) & ~complete;
    assign immed_start = has_immediate & modrm_byte_read;
    assign immed_is_8bit = mode == 2'b01;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            started <= 1'b0;
        else if (complete)
            started <= 1'b0;
        else if (start)
            started <= 1'b1;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            modrm_byte_read <= 1'b0;
            latch_modrm_byte <= 1'b0;
            registers_fetched <= 1'b0;
        end else if (complete) begin
            modrm_byte_read <= 1'b0;
            latch_modrm_byte <= 1'b0;
            registers_fetched <= 1'b0;
        end else begin
            latch_modrm_byte <= fifo_rd_en;
            if (fifo_rd_en)
                modrm_byte_read <= 1'b1;
            if (modrm_byte_read)
                registers_fetched <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            modrm <= '0;
        else if (clear)
            modrm <= '0;
        else if (latch_modrm_byte)
            modrm <= fifo_rd_data;
    end

    // ======================================================================
    // Register selection and address arithmetic
    // ======================================================================

    // 8086 table: BX or BP as base, SI or DI as index for r/m 0 to 3
    always_comb begin
        case (rm_field)
            3'b000, 3'b001, 3'b111: reg_sel_base = REG_BX;
            3'b010, 3'b011, 3'b110: reg_sel_base = REG_BP;
            3'b100: reg_sel_base = REG_SI;
            default: reg_sel_base = REG_DI;
        endcase

        case (rm_field)
            3'b000, 3'b010: reg_sel_index = REG_SI;
            3'b001, 3'b011: reg_sel_index = REG_DI;
            default: reg_sel_index = REG_AX;
        endcase
    end

    assign displacement = (mode == 2'b00) ? 16'h0000 : immediate;

    always_comb begin
        if (direct_address)
            calc_address = immediate;
        else if (!rm_field[2])
            calc_address = base_value + index_value + displacement;
        else
            calc_address = base_value + displacement;
    end

    always_ff @(posedge clk) begin
        if (complete)
            cached_address <= calc_address;
    end

    assign effective_address = complete ? calc_address : cached_address;

    assign regnum = reg_field;
    assign rm_regnum = rm_field;
    assign rm_is_reg = ~has_address;
    assign bp_as_base = has_address &&
                        (rm_field == 3'b010 || rm_field == 3'b011 ||
                         (rm_field == 3'b110 && mode != 2'b00));

endmodule

//--- source/modrm_unit.sv
module modrm_unit import x86_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     wr_en,
    input  byte_t    wr_data,
    output logic     full,
    input  logic     reg_wr_en,
    input  reg_num_t reg_wr_sel,
    input  word_t    reg_wr_data,
    input  logic     start,
    input  logic     clear,
    output logic     busy,
    output logic     complete,
    output word_t    effective_address,
    output reg_num_t regnum,
    output logic     rm_is_reg,
    output reg_num_t rm_regnum,
    output logic     bp_as_base
);

    logic fifo_rd_en;
    logic decode_rd_en;
    logic immed_rd_en;
    byte_t fifo_rd_data;
    logic fifo_empty;
    reg_num_t reg_sel_base;
    reg_num_t reg_sel_index;
    word_t base_value;
    word_t index_value;
    logic immed_start;
    logic immed_is_8bit;
    logic immed_complete;
    word_t immediate;

    // The reader only starts after the ModR/M pop, so the enables never overlap
    assign fifo_rd_en = decode_rd_en | immed_rd_en;

    prefetch_fifo i_fifo (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .full    (full),
        .rd_en   (fifo_rd_en),
        .rd_data (fifo_rd_data),
        .empty   (fifo_empty)
    );

    register_file i_regs (
        .clk         (clk),
        .reset       (reset),
        .wr_en       (reg_wr_en),
        .wr_sel      (reg_wr_sel),
        .wr_data     (reg_wr_data),
        .sel_base    (reg_sel_base),
        .sel_index   (reg_sel_index),
        .base_value  (base_value),
        .index_value (index_value)
    );

    immediate_reader i_immed (
        .clk          (clk),
        .reset        (reset),
        .start        (immed_start),
        .is_8bit      (immed_is_8bit),
        .fifo_rd_en   (immed_rd_en),
        .fifo_rd_data (fifo_rd_data),
        .fifo_empty   (fifo_empty),
        .complete     (immed_complete),
        .immediate    (immediate)
    );

    modrm_decode i_decode (
        .clk               (clk),
        .reset             (reset),
        .start             (start),
        .busy              (busy),
        .complete          (complete),
        .clear             (clear),
        .effective_address (effective_address),
        .regnum            (regnum),
        .rm_is_reg         (rm_is_reg),
        .rm_regnum         (rm_regnum),
        .bp_as_base        (bp_as_base),
        .reg_sel_base      (reg_sel_base),
        .reg_sel_index     (reg_sel_index),
        .base_value        (base_value),
        .index_value       (index_value),
        .fifo_rd_en        (decode_rd_en),
        .fifo_rd_data      (fifo_rd_data),
        .fifo_empty        (fifo_empty),
        .immed_start       (immed_start),
        .immed_complete    (immed_complete),
        .immed_is_8bit     (immed_is_8bit),
        .immediate         (immediate)
    );

endmodule

//--- bench/modrm_unit_tb.sv
module modrm_unit_tb import x86_pkg::*; ();

    localparam int RESET_CYCLES = 8;
    localparam int CYCLES_PER_LINE = 40;
    localparam string TRACE_FILE = "bench/modrm_trace.txt";

    logic     clk;
    logic     reset;
    logic     wr_en;
    byte_t    wr_data;
    logic     full;
    logic     reg_wr_en;
    reg_num_t reg_wr_sel;
    word_t    reg_wr_data;
    logic     start;
    logic     clear;
    logic     busy;
    logic     complete;
    word_t    effective_address;
    reg_num_t regnum;
    logic     rm_is_reg;
    reg_num_t rm_regnum;
    logic     bp_as_base;

    string trace_lines[$];
    int cycle_count = 0;
    int cycle_limit = 0;

    // ======================================================================
    // DUT and clock
    // ======================================================================

    modrm_unit i_dut (
        .clk               (clk),
        .reset             (reset),
        .wr_en             (wr_en),
        .wr_data           (wr_data),
        .full              (full),
        .reg_wr_en         (reg_wr_en),
        .reg_wr_sel        (reg_wr_sel),
        .reg_wr_data       (reg_wr_data),
        .start             (start),
        .clear             (clear),
        .busy              (busy),
        .complete          (complete),
        .effective_address (effective_address),
        .regnum            (regnum),
        .rm_is_reg         (rm_is_reg),
        .rm_regnum         (rm_regnum),
        .bp_as_base        (bp_as_base)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit)
            abort_run($sformatf("Timeout after %0d cycles, the trace did not finish",
                                cycle_count));
    end

    // ======================================================================
    // Helpers
    // ======================================================================

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        assert (actual === expected)
        else abort_run($sformatf("[FAIL] %s: got %h, expected %h", name, actual, expected));
    endtask

    task automatic load_trace();
        int fd;
        string line;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0)
            abort_run($sformatf("Could not open the trace file %s", TRACE_FILE));
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#")
                trace_lines.push_back(line);
        end
        $fclose(fd);
    endtask

    // Every drive happens shortly after the rising edge and the write strobes default low
    task automatic next_cycle();
        @(posedge clk);
        #1;
        reg_wr_en = 1'b0;
        wr_en = 1'b0;
    endtask

    task automatic write_register(input reg_num_t sel, input word_t value);
        next_cycle();
        reg_wr_en = 1'b1;
        reg_wr_sel = sel;
        reg_wr_data = value;
    endtask

    // A decode never leaves more than three bytes behind, so the FIFO is never full here
    task automatic push_byte(input byte_t value);
        next_cycle();
        check_value("full", 16'(full), 16'h0000);
        wr_en = 1'b1;
        wr_data = value;
    endtask

    // Outputs are sampled at the falling edge where they have settled
    task automatic await_result(input word_t exp_ea, input reg_num_t exp_reg,
                                input logic exp_rm_is_reg, input reg_num_t exp_rm_reg,
                                input logic exp_bp, input int exp_latency);
        int latency;
        latency = 0;
        @(negedge clk);
        while (!complete) begin
            check_value("busy", 16'(busy), 16'h0001);
            latency++;
            @(negedge clk);
        end
        if (exp_latency >= 0)
            check_value("latency in cycles", 16'(latency), 16'(exp_latency));
        // The address has no meaning for a register operand
        if (!exp_rm_is_reg)
            check_value("effective_address", effective_address, exp_ea);
        check_value("regnum", 16'(regnum), 16'(exp_reg));
        check_value("rm_is_reg", 16'(rm_is_reg), 16'(exp_rm_is_reg));
        check_value("rm_regnum", 16'(rm_regnum), 16'(exp_rm_reg));
        check_value("bp_as_base", 16'(bp_as_base), 16'(exp_bp));
        check_value("busy", 16'(busy), 16'h0000);
        @(posedge clk);
        #1;
        start = 1'b0;
        @(negedge clk);
        check_value("complete", 16'(complete), 16'h0000);
        check_value("busy", 16'(busy), 16'h0000);
        if (!exp_rm_is_reg)
            check_value("effective_address", effective_address, exp_ea);
    endtask

    task automatic run_line(input string line);
        word_t bx;
        word_t bp;
        word_t si;
        word_t di;
        byte_t modrm;
        int nbytes;
        byte_t disp_lo;
        byte_t disp_hi;
        int gap;
        word_t exp_ea;
        reg_num_t exp_reg;
        logic exp_rm_is_reg;
        reg_num_t exp_rm_reg;
        logic exp_bp;
        int exp_latency;
        int fields;
        fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         bx, bp, si, di, modrm, nbytes, disp_lo, disp_hi, gap,
                         exp_ea, exp_reg, exp_rm_is_reg, exp_rm_reg, exp_bp);
        if (fields != 14)
            abort_run($sformatf("Trace line could not be parsed: %s", line));
        write_register(REG_BX, bx);
        write_register(REG_BP, bp);
        write_register(REG_SI, si);
        write_register(REG_DI, di);
        // Register mode needs one cycle and each address stage or byte adds one
        if (modrm[7:6] == 2'b11)
            exp_latency = 1;
        else
            exp_latency = 2 + nbytes;
        if (gap == 0) begin
            push_byte(modrm);
            if (nbytes > 0)
                push_byte(disp_lo);
            if (nbytes > 1)
                push_byte(disp_hi);
            next_cycle();
            start = 1'b1;
            await_result(exp_ea, exp_reg, exp_rm_is_reg, exp_rm_reg, exp_bp, exp_latency);
        end else begin
            next_cycle();
            start = 1'b1;
            wr_en = 1'b1;
            wr_data = modrm;
            fork
                begin
                    if (nbytes > 0) begin
                        next_cycle();
                        push_byte(disp_lo);
                    end
                    if (nbytes > 1) begin
                        next_cycle();
                        push_byte(disp_hi);
                    end
                    next_cycle();
                end
                await_result(exp_ea, exp_reg, exp_rm_is_reg, exp_rm_reg, exp_bp, -1);
            join
        end
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        wr_en = 1'b0;
        wr_data = '0;
        reg_wr_en = 1'b0;
        reg_wr_sel = REG_AX;
        reg_wr_data = '0;
        start = 1'b0;
        clear = 1'b0;
        load_trace();
        cycle_limit = CYCLES_PER_LINE * trace_lines.size() + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        foreach (trace_lines[i])
            run_line(trace_lines[i]);
        next_cycle();
        if (trace_lines.size() > 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            abort_run("The trace file holds no decode lines");
        end
    end

endmodule

//--- bench/modrm_trace.txt
# bx bp si di modrm nbytes disp_lo disp_hi gap ea regnum rm_is_reg rm_regnum bp_as_base
# All columns in hex, ea is not checked for register-mode lines
1234 2000 0456 0100 d5 0 00 00 0 0000 2 1 5 0
1234 2000 0456 0100 f8 0 00 00 0 0000 7 1 0 0
1234 2000 0456 0100 00 0 00 00 0 168a 0 0 0 0
1234 2000 0456 0100 12 0 00 00 0 2456 2 0 2 1
1234 2000 0456 0100 1b 0 00 00 0 2100 3 0 3 1
1234 2000 0456 0100 24 0 00 00 0 0456 4 0 4 0
1234 2000 0456 0100 2d 0 00 00 0 0100 5 0 5 0
1234 2000 0456 0100 37 0 00 00 0 1234 6 0 7 0
1234 2000 0456 0100 06 2 cd ab 0 abcd 0 0 6 0
ff00 2000 0234 0100 00 0 00 00 0 0134 0 0 0 0
1234 2000 0456 0100 48 1 05 00 0 168f 1 0 0 0
1234 2000 0456 0100 56 1 80 00 0 1f80 2 0 6 1
1234 2000 0456 0100 5b 1 ff 00 0 20ff 3 0 3 1
1234 2000 0456 0100 67 1 f0 00 0 1224 4 0 7 0
1234 2000 0456 0100 a9 2 00 10 0 2334 5 0 1 0
1234 2000 0456 0100 b6 2 23 01 0 2123 6 0 6 1
1234 2000 0456 0100 ba 2 fe ff 0 2454 7 0 2 1
1234 2000 0456 0100 03 0 00 00 1 2100 0 0 3 1
1234 2000 0456 0100 4c 1 9c 00 1 03f2 1 0 4 0
1234 2000 0456 0100 90 2 78 56 1 6d02 2 0 0 0
1234 2000 0456 0100 1e 2 ef be 1 beef 3 0 6 0
1234 2000 0456 0100 e3 0 00 00 1 0000 4 1 3 0

//--- modrm_unit.f
source/x86_pkg.sv
source/prefetch_fifo.sv
source/register_file.sv
source/immediate_reader.sv
source/modrm_decode.sv
source/modrm_unit.sv
bench/modrm_unit_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := modrm_unit_tb
FILELIST  := modrm_unit.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q -- "$(PASS_MSG)" $(LOG); then echo "Simulation passed"; \
	else echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
